// File: design/corr_config.svh
`ifndef CORR_CONFIG_SVH
`define CORR_CONFIG_SVH

// ----------------------------------------
// Datapath widths
// ----------------------------------------
`define ACCUM_BITS  8   // Signed width of each Re/Im accumulator
`define NUM_ANTENNA 8   // One sample bit per antenna

// ----------------------------------------
// Time multiplexing and banking
// ----------------------------------------
`define TRATE       4   // Slots per pass, >= 3 keeps RMW apart
`define SLOT_BITS   2
`define BLOCK_BITS  2   // Four banks
`define NUM_LANES   2

// Pair tables, byte per slot (slot 0 in low byte), antenna A in high nibble
`define PAIRS_LANE0 32'h12030201
`define PAIRS_LANE1 32'h46674523

`endif

// File: design/corr_types_pkg.sv
`include "corr_config.svh"

package corr_types_pkg;

   // Raw one-bit antenna samples
   typedef logic [`NUM_ANTENNA-1:0] sample_t;

   typedef logic [`SLOT_BITS-1:0]  slot_t;   // Time-multiplex slot
   typedef logic [`BLOCK_BITS-1:0] block_t;  // Bank index

   // Wrapping signed accumulator
   typedef logic signed [`ACCUM_BITS-1:0] accum_t;

   // One visibility, real part in the upper byte
   typedef struct packed {
      accum_t re;
      accum_t im;
   } vis_t;

   // Sequencer bank control
   typedef enum logic [1:0] {
      IDLE,            // Not enabled, no samples
      RUN,             // Accumulating into current bank
      SWITCH_PENDING,  // Switch requested, waiting for slot wrap
      CLEARING         // Pass that restarts every slot from zero
   } bank_state_e;

endpackage

// File: design/wb_bus_pkg.sv
`include "corr_config.svh"

package wb_bus_pkg;

   // Bus address, MSB first
   typedef struct packed {
      logic [`BLOCK_BITS-1:0] block;  // Bank
      logic [`SLOT_BITS-1:0]  slot;
      logic                   lane;
      logic                   comp;   // 0 real, 1 imaginary
   } wb_addr_t;

   typedef logic [`ACCUM_BITS-1:0] wb_data_t;  // One accumulator byte

   // Slave side of a classic cycle
   typedef enum logic {
      WB_IDLE,
      WB_ACK
   } wb_cycle_e;

endpackage

// File: design/corr_stream_if.sv
`timescale 1ns/10ps

// Sample stream from the sequencer to the lanes, no back-pressure
interface corr_stream_if import corr_types_pkg::*; ();

   logic    valid;  // Sample present this cycle
   slot_t   slot;   // Slot the sample belongs to
   logic    clear;  // Start from zero, ignore stored accumulator
   block_t  block;  // Bank tag travelling with the sample
   sample_t re;
   sample_t im;

   // Driver side
   modport seq_mp (
      output valid, slot, clear, block, re, im
   );

   // Lane side, read only
   modport lane_mp (
      input valid, slot, clear, block, re, im
   );

endinterface

// File: design/corr_sequencer.sv
`timescale 1ns/10ps
`include "corr_config.svh"

module corr_sequencer import corr_types_pkg::*; (
   input  logic    clk_x,
   input  logic    rst,
   input  logic    en_i,    // Sample valid at the ports
   input  logic    sw_i,    // Bank switch request pulse
   input  sample_t re_i,
   input  sample_t im_i,
   corr_stream_if.seq_mp stream
);

   localparam slot_t LAST_SLOT = slot_t'(`TRATE - 1);

   bank_state_e state;
   slot_t       clr_cnt;   // Samples seen in the clearing pass
   logic        sw_hold;   // Switch seen while clearing
   logic        wrap;
   logic        last_clr;
   logic        pending;

   assign wrap     = stream.valid && (stream.slot == LAST_SLOT);  // Last slot consumed
   assign last_clr = stream.valid && (clr_cnt == LAST_SLOT);
   assign pending  = (state == SWITCH_PENDING) || sw_hold || sw_i;

   // Lanes restart every slot while idle or clearing
   assign stream.clear = (state == IDLE) || (state == CLEARING);

   // ----------------------------------------
   // Sample register and slot counter
   // ----------------------------------------
   always_ff @(posedge clk_x) begin
      stream.re <= re_i;
      stream.im <= im_i;
      if (rst) begin
         stream.valid <= 1'b0;
         stream.slot  <= '0;
      end else begin
         stream.valid <= en_i;
         if (stream.valid) begin
            stream.slot <= wrap ? '0 : stream.slot + 1'b1;  // Holds while idle
         end
      end
   end

   // ----------------------------------------
   // Bank FSM
   // ----------------------------------------
   always_ff @(posedge clk_x) begin
      if (rst) begin
         state        <= IDLE;
         stream.block <= '0;
         clr_cnt      <= '0;
         sw_hold      <= 1'b0;
      end else if (!en_i) begin
         // Stopped, so an outstanding switch takes effect now
         state   <= IDLE;
         sw_hold <= 1'b0;
         if (pending) stream.block <= stream.block + 1'b1;
      end else begin
         case (state)
            IDLE: begin
               if (sw_i) stream.block <= stream.block + 1'b1;
               clr_cnt <= '0;
               state   <= CLEARING;  // Restart always begins with a clear
            end
            RUN: begin
               if (wrap && sw_i) begin
                  stream.block <= stream.block + 1'b1;
                  clr_cnt      <= '0;
                  state        <= CLEARING;
               end else if (sw_i) begin
                  state <= SWITCH_PENDING;
               end
            end
            SWITCH_PENDING: begin
               if (wrap) begin
                  stream.block <= stream.block + 1'b1;  // Next sample is slot 0
                  clr_cnt      <= '0;
                  state        <= CLEARING;
               end
            end
            CLEARING: begin
               if (sw_i) sw_hold <= 1'b1;
               if (last_clr) begin
                  // Whole pass done, every slot restarted once
                  sw_hold <= 1'b0;
                  state   <= (sw_hold || sw_i) ? SWITCH_PENDING : RUN;
               end else if (stream.valid) begin
                  clr_cnt <= clr_cnt + 1'b1;
               end
            end
         endcase
      end
   end

endmodule

// File: design/corr_lane.sv
`timescale 1ns/10ps
`include "corr_config.svh"

module corr_lane import corr_types_pkg::*; #(
   parameter logic [8*`TRATE-1:0] PAIRS = `PAIRS_LANE0  // One byte per slot
) (
   input  logic   clk_x,
   input  logic   rst,
   corr_stream_if.lane_mp stream,
   output logic   vis_we_o,
   output slot_t  vis_slot_o,
   output block_t vis_block_o,
   output vis_t   vis_o,
   output logic   overflow_re_o,  // Sticky until reset
   output logic   overflow_im_o
);

   localparam int IDX_BITS = $clog2(`NUM_ANTENNA);
   localparam int MSB      = `ACCUM_BITS - 1;

   typedef logic signed [2:0] prod_t;  // Holds -2..+2

   // Product of two one-bit samples, 1 means +1 and 0 means -1
   function automatic prod_t sign_mul(input logic x, input logic y);
      return (x == y) ? 3'sd1 : -3'sd1;
   endfunction

   logic [7:0]          pair;
   logic [IDX_BITS-1:0] ant_a;
   logic [IDX_BITS-1:0] ant_b;
   prod_t               prod_re;
   prod_t               prod_im;
   vis_t                acc_mem [`TRATE];  // One accumulator per slot
   vis_t                base;
   vis_t                sum;
   logic                ovf_re;
   logic                ovf_im;

   // Stage 1 registers
   logic                s1_valid;
   slot_t               s1_slot;
   block_t              s1_block;
   vis_t                s1_vis;
   logic                s1_ovf_re;
   logic                s1_ovf_im;

   // ----------------------------------------
   // Stage 1, pair select and complex MAC
   // ----------------------------------------
   assign pair  = PAIRS[stream.slot*8 +: 8];
   assign ant_a = pair[4 +: IDX_BITS];
   assign ant_b = pair[0 +: IDX_BITS];

   // a times conj(b)
   assign prod_re = sign_mul(stream.re[ant_a], stream.re[ant_b])
                  + sign_mul(stream.im[ant_a], stream.im[ant_b]);
   assign prod_im = sign_mul(stream.im[ant_a], stream.re[ant_b])
                  - sign_mul(stream.re[ant_a], stream.im[ant_b]);

   assign base   = stream.clear ? '0 : acc_mem[stream.slot];  // Zero input on clear
   assign sum.re = base.re + prod_re;
   assign sum.im = base.im + prod_im;

   // Wrap when both operands share a sign and the sum flips it
   assign ovf_re = (base.re[MSB] == prod_re[2]) && (sum.re[MSB] != base.re[MSB]);
   assign ovf_im = (base.im[MSB] == prod_im[2]) && (sum.im[MSB] != base.im[MSB]);

   always_ff @(posedge clk_x) begin
      if (rst) s1_valid <= 1'b0;
      else     s1_valid <= stream.valid;
   end

   always_ff @(posedge clk_x) begin
      s1_slot   <= stream.slot;
      s1_block  <= stream.block;  // Bank the sample started in
      s1_vis    <= sum;
      s1_ovf_re <= ovf_re;
      s1_ovf_im <= ovf_im;
   end

   // ----------------------------------------
   // Stage 2, write back and flags
   // ----------------------------------------
   always_ff @(posedge clk_x) begin
      if (s1_valid) acc_mem[s1_slot] <= s1_vis;
   end

   always_ff @(posedge clk_x) begin
      if (rst) begin
         overflow_re_o <= 1'b0;
         overflow_im_o <= 1'b0;
      end else if (s1_valid) begin
         if (s1_ovf_re) overflow_re_o <= 1'b1;
         if (s1_ovf_im) overflow_im_o <= 1'b1;
      end
   end

   // Buffer stores the same word at the same edge
   assign vis_we_o    = s1_valid;
   assign vis_slot_o  = s1_slot;
   assign vis_block_o = s1_block;
   assign vis_o       = s1_vis;

endmodule

// File: design/vis_buffer_wb.sv
`timescale 1ns/10ps
`include "corr_config.svh"

module vis_buffer_wb import corr_types_pkg::*, wb_bus_pkg::*; (
   input  logic     clk_x,
   input  logic     rst,

   // Lane write ports
   input  logic     vis_we_i    [`NUM_LANES],
   input  slot_t    vis_slot_i  [`NUM_LANES],
   input  block_t   vis_block_i [`NUM_LANES],
   input  vis_t     vis_i       [`NUM_LANES],

   // Wishbone classic slave
   input  logic     cyc_i,
   input  logic     stb_i,
   input  logic     we_i,    // Writes acked, no effect
   input  wb_addr_t adr_i,
   output logic     ack_o,
   output wb_data_t dat_o
);

   localparam int DEPTH = 1 << (`BLOCK_BITS + `SLOT_BITS);  // Banks times slots

   vis_t      vis_mem [`NUM_LANES][DEPTH];
   vis_t      rd_word;
   wb_data_t  rd_byte;
   logic      req;
   wb_cycle_e wb_state;

   // ----------------------------------------
   // Lane side, both lanes write together
   // ----------------------------------------
   always_ff @(posedge clk_x) begin
      for (int l = 0; l < `NUM_LANES; l++) begin
         if (vis_we_i[l]) begin
            vis_mem[l][{vis_block_i[l], vis_slot_i[l]}] <= vis_i[l];
         end
      end
   end

   // ----------------------------------------
   // Bus side
   // ----------------------------------------
   assign req     = cyc_i && stb_i;
   assign rd_word = vis_mem[adr_i.lane][{adr_i.block, adr_i.slot}];
   assign rd_byte = adr_i.comp ? rd_word.im : rd_word.re;  // Word select

   // Single-cycle ack, held off until stb drops
   always_ff @(posedge clk_x) begin
      if (rst) begin
         wb_state <= WB_IDLE;
         ack_o    <= 1'b0;
      end else begin
         ack_o <= 1'b0;
         case (wb_state)
            WB_IDLE: begin
               if (req) begin
                  wb_state <= WB_ACK;
                  ack_o    <= 1'b1;
               end
            end
            WB_ACK: begin
               if (!req) wb_state <= WB_IDLE;  // Master released the strobe
            end
         endcase
      end
   end

   // Read data registered with the ack
   always_ff @(posedge clk_x) begin
      if (wb_state == WB_IDLE && req && !we_i) dat_o <= rd_byte;
   end

endmodule

// File: design/correlator_top.sv
`timescale 1ns/10ps
`include "corr_config.svh"

module correlator_top import corr_types_pkg::*, wb_bus_pkg::*; (
   input  logic     clk_x,
   input  logic     rst,

   // Antenna side
   input  logic     en_i,
   input  logic     sw_i,
   input  sample_t  re_i,
   input  sample_t  im_i,

   // Wishbone classic slave
   input  logic     cyc_i,
   input  logic     stb_i,
   input  logic     we_i,
   input  wb_addr_t adr_i,
   input  wb_data_t dat_i,   // Write data accepted and dropped
   output logic     ack_o,
   output wb_data_t dat_o,

   output logic     overflow_re_o,
   output logic     overflow_im_o
);

   // Lane to buffer
   logic                   vis_we    [`NUM_LANES];
   slot_t                  vis_slot  [`NUM_LANES];
   block_t                 vis_block [`NUM_LANES];
   vis_t                   vis       [`NUM_LANES];
   logic [`NUM_LANES-1:0]  ovf_re;
   logic [`NUM_LANES-1:0]  ovf_im;

   corr_stream_if stream_if ();

   corr_sequencer corr_sequencer_i (
      .clk_x  (clk_x),
      .rst    (rst),
      .en_i   (en_i),
      .sw_i   (sw_i),
      .re_i   (re_i),
      .im_i   (im_i),
      .stream (stream_if.seq_mp)
   );

   // ----------------------------------------
   // Lanes, each with its own pair table
   // ----------------------------------------
   for (genvar l = 0; l < `NUM_LANES; l++) begin : g_lane
      corr_lane #(
         .PAIRS ((l == 0) ? `PAIRS_LANE0 : `PAIRS_LANE1)
      ) corr_lane_i (
         .clk_x         (clk_x),
         .rst           (rst),
         .stream        (stream_if.lane_mp),
         .vis_we_o      (vis_we[l]),
         .vis_slot_o    (vis_slot[l]),
         .vis_block_o   (vis_block[l]),
         .vis_o         (vis[l]),
         .overflow_re_o (ovf_re[l]),
         .overflow_im_o (ovf_im[l])
      );
   end

   vis_buffer_wb vis_buffer_wb_i (
      .clk_x       (clk_x),
      .rst         (rst),
      .vis_we_i    (vis_we),
      .vis_slot_i  (vis_slot),
      .vis_block_i (vis_block),
      .vis_i       (vis),
      .cyc_i       (cyc_i),
      .stb_i       (stb_i),
      .we_i        (we_i),
      .adr_i       (adr_i),
      .ack_o       (ack_o),
      .dat_o       (dat_o)
   );

   assign overflow_re_o = |ovf_re;  // Any lane
   assign overflow_im_o = |ovf_im;

endmodule

// File: verif/tb_correlator.sv
`timescale 1ns/10ps
`include "corr_config.svh"

module tb_correlator import corr_types_pkg::*, wb_bus_pkg::*; ();

   localparam int MAX_CYCLES = 3000;  // Tests need about 500 cycles
   localparam int NUM_BLOCKS = 1 << `BLOCK_BITS;
   localparam logic [8*`TRATE-1:0] PAIR_TAB [`NUM_LANES] = '{`PAIRS_LANE0, `PAIRS_LANE1};

   logic     clk_x = 1'b0;
   logic     rst;
   logic     en_i, sw_i, cyc_i, stb_i, we_i, ack_o;
   sample_t  re_i, im_i;
   wb_addr_t adr_i;
   wb_data_t dat_i, dat_o;
   logic     overflow_re_o, overflow_im_o;

   // Reference model state
   block_t     m_block;
   slot_t      m_slot;
   int         clear_left;         // Samples left in the clearing pass
   logic       sw_pend;
   logic [1:0] m_ovf;              // Bit 1 imaginary, bit 0 real
   logic [1:0] ovf_q [3];          // Model flags of the last three samples
   int         acc_re [`NUM_LANES][`TRATE];
   int         acc_im [`NUM_LANES][`TRATE];
   int         exp_re [NUM_BLOCKS][`TRATE][`NUM_LANES];
   int         exp_im [NUM_BLOCKS][`TRATE][`NUM_LANES];
   logic       bus_used = 1'b0;
   int         cycle_cnt = 0;
   integer     seed;

   correlator_top correlator_top_i (.*);

   always #2 clk_x = ~clk_x;  // 4 ns period

   task automatic abort_run();
      $display("Errors found");
      $fatal(1);
   endtask

   // ----------------------------------------
   // Bus protocol checks
   // ----------------------------------------
   idle_before_bus: assert property (@(posedge clk_x) disable iff (rst)
      !bus_used |-> !ack_o && !overflow_re_o && !overflow_im_o)
      else begin
         $display("error: ack or overflow active before any bus request");
         abort_run();
      end

   ack_needs_req: assert property (@(posedge clk_x) disable iff (rst)
      ack_o |-> $past(cyc_i && stb_i))
      else begin
         $display("error: ack_o raised without a bus request");
         abort_run();
      end

   ack_follows_req: assert property (@(posedge clk_x) disable iff (rst)
      $rose(cyc_i && stb_i) |=> ack_o)
      else begin
         $display("error: ack_o missing one cycle after the request");
         abort_run();
      end

   ack_one_cycle: assert property (@(posedge clk_x) disable iff (rst) ack_o |=> !ack_o)
      else begin
         $display("error: ack_o held longer than one cycle");
         abort_run();
      end

   always @(posedge clk_x) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == MAX_CYCLES) begin
         $display("error: run did not finish within %0d cycles", MAX_CYCLES);
         abort_run();
      end
   end

   function automatic int sign_of(input logic x);
      return x ? 1 : -1;  // Sample bit 1 is +1
   endfunction

   function automatic int wrap_to_byte(input int v);
      if (v > 127) return v - 256;
      if (v < -128) return v + 256;
      return v;
   endfunction

   task automatic check_value(input string test, input int exp, input int act);
      assert (act == exp) else begin
         $display("error: %s expected %0d actual %0d", test, exp, act);
         abort_run();
      end
   endtask

   task automatic apply_reset();
      rst = 1'b1;
      en_i = 1'b0;
      sw_i = 1'b0;
      repeat (3) @(posedge clk_x);
      @(negedge clk_x);
      rst = 1'b0;
      m_block = '0;
      m_slot = '0;
      clear_left = `TRATE;  // First enable starts with a clearing pass
      sw_pend = 1'b0;
      m_ovf = '0;
      ovf_q = '{default: '0};
   endtask

   // ----------------------------------------
   // Stimulus with model update
   // ----------------------------------------
   task automatic drive_sample(input sample_t re, input sample_t im, input logic sw);
      logic [7:0] pair;
      int a, b, pr, pi, nr, ni;
      logic clr;
      @(negedge clk_x);
      // DUT flag trails the model by three samples
      check_value("overflow flags", ovf_q[2], {overflow_im_o, overflow_re_o});
      en_i = 1'b1;
      sw_i = sw;
      re_i = re;
      im_i = im;
      if (sw) sw_pend = 1'b1;
      if (m_slot == 0 && sw_pend) begin  // Switch lands on a slot wrap
         m_block++;
         clear_left = `TRATE;
         sw_pend = 1'b0;
      end
      clr = (clear_left > 0);
      if (clr) clear_left--;
      for (int l = 0; l < `NUM_LANES; l++) begin
         pair = PAIR_TAB[l][8*int'(m_slot) +: 8];
         a = pair[7:4];
         b = pair[3:0];
         // a times conj(b)
         pr = sign_of(re[a]) * sign_of(re[b]) + sign_of(im[a]) * sign_of(im[b]);
         pi = sign_of(im[a]) * sign_of(re[b]) - sign_of(re[a]) * sign_of(im[b]);
         nr = (clr ? 0 : acc_re[l][m_slot]) + pr;
         ni = (clr ? 0 : acc_im[l][m_slot]) + pi;
         if (nr > 127 || nr < -128) m_ovf[0] = 1'b1;
         if (ni > 127 || ni < -128) m_ovf[1] = 1'b1;
         acc_re[l][m_slot] = wrap_to_byte(nr);
         acc_im[l][m_slot] = wrap_to_byte(ni);
         exp_re[m_block][m_slot][l] = acc_re[l][m_slot];
         exp_im[m_block][m_slot][l] = acc_im[l][m_slot];
      end
      m_slot++;
      ovf_q[2] = ovf_q[1];
      ovf_q[1] = ovf_q[0];
      ovf_q[0] = m_ovf;
   endtask

   // Pipeline drains three edges after the last sample
   task automatic stop_samples();
      @(negedge clk_x);
      en_i = 1'b0;
      sw_i = 1'b0;
      repeat (3) @(negedge clk_x);
   endtask

   task automatic bus_access(input logic write, input wb_addr_t adr, input wb_data_t wdata,
                             output wb_data_t rdata);
      @(negedge clk_x);
      cyc_i = 1'b1;
      stb_i = 1'b1;
      we_i = write;
      adr_i = adr;
      dat_i = wdata;
      bus_used = 1'b1;
      do @(negedge clk_x); while (!ack_o);  // Master holds until ack
      rdata = dat_o;
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i = 1'b0;
   endtask

   task automatic check_block(input block_t blk, input string test);
      wb_addr_t adr;
      wb_data_t rd;
      for (int s = 0; s < `TRATE; s++) begin
         for (int l = 0; l < `NUM_LANES; l++) begin
            for (int c = 0; c < 2; c++) begin
               adr.block = blk;
               adr.slot = slot_t'(s);
               adr.lane = l[0];
               adr.comp = c[0];
               bus_access(1'b0, adr, '0, rd);
               check_value($sformatf("%s slot %0d lane %0d comp %0d", test, s, l, c),
                           c ? exp_im[blk][s][l] : exp_re[blk][s][l], $signed(rd));
            end
         end
      end
   endtask

   // ----------------------------------------
   // Test sequence
   // ----------------------------------------
   initial begin
      int r;
      wb_addr_t adr;
      wb_data_t rd;
      seed = 32'h8bddae0d;
      rst = 1'b1;
      en_i = 1'b0;
      sw_i = 1'b0;
      re_i = '0;
      im_i = '0;
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i = 1'b0;
      adr_i = '0;
      dat_i = '0;
      apply_reset();

      // Random accumulation, then switch to block 1 for two passes
      for (int p = 0; p < 10 * `TRATE; p++) begin
         r = $random(seed);
         drive_sample(r[7:0], r[15:8], 1'b0);
      end
      for (int p = 0; p < 2 * `TRATE; p++) begin
         r = $random(seed);
         drive_sample(r[7:0], r[15:8], p == 0);
      end
      stop_samples();
      check_block(0, "accumulate block 0");
      check_block(1, "switched block 1");

      adr = '0;
      adr.slot = 2'd1;
      bus_access(1'b1, adr, 8'h5a, rd);  // Write must leave memory alone
      bus_access(1'b0, adr, '0, rd);
      check_value("ignored write", exp_re[0][1][0], $signed(rd));
      check_block(0, "reread block 0");

      // Constant samples, lane 0 real grows by 2 per pass
      apply_reset();
      check_value("flags after reset", 0, {overflow_im_o, overflow_re_o});
      for (int p = 0; p < 70 * `TRATE; p++) drive_sample('1, '1, 1'b0);
      stop_samples();
      check_value("overflow after run", m_ovf, {overflow_im_o, overflow_re_o});
      check_block(0, "wrapped block 0");
      apply_reset();
      check_value("flags cleared by reset", 0, {overflow_im_o, overflow_re_o});

      $display("No errors");
      $finish;
   end

endmodule

// File: files.f
+incdir+design
design/corr_types_pkg.sv
design/wb_bus_pkg.sv
design/corr_stream_if.sv
design/corr_sequencer.sv
design/corr_lane.sv
design/vis_buffer_wb.sv
design/correlator_top.sv
verif/tb_correlator.sv

// File: run.sh
#!/bin/sh
# Build the correlator testbench with Verilator, run it, then judge the log
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_correlator \
   -f files.f -o sim_correlator > build.log 2>&1 \
   && ./obj_dir/sim_correlator > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "FAIL"; exit 1; }
grep -q "No errors" sim.log \
   && echo "PASS" \
   || { cat sim.log; echo "FAIL"; exit 1; }
